// ==== bench/harness_stim.txt ====
# op addr data expected; W write, R read and compare, E error expected, P data is switch pattern
# G: data is gpio_i pulse count, expected is gpio_o pulse count, addr is irq_o level afterwards
W 00000000 deadbeef 00000000
W 00000004 12345678 00000000
W 00000ffc a5a5a5a5 00000000
R 00000000 00000000 deadbeef
R 00000004 00000000 12345678
R 00000ffc 00000000 a5a5a5a5
R 00000008 00000000 00000000
R 00000005 00000000 12345678
E 00001000 00000000 00000000
E 00010010 00000000 00000000
E 80000000 00000000 00000000
R 00010004 00000000 00000800
W 00010004 00001234 00000000
R 00010004 00000000 00001234
W 00010000 00000055 00000000
R 00010000 00000000 00000000
R 0001000c 00000000 00000000
W 00010004 00000005 00000000
G 00000001 00000007 00000001
R 00010000 00000000 00000002
R 00010008 00000000 00000001
W 00010008 00000001 00000000
G 00000000 00000000 00000000
R 00010008 00000000 00000000
P 00000000 00000005 00000000
P 00000000 00000002 00000000
P 00000000 00000007 00000000
P 00000000 00000000 00000000
P 00000000 00000006 00000000

// ==== project.f ====
common/harness_pkg.sv
source/reg_decoder.sv
slow_memory/slow_memory.sv
source/gpio_counter.sv
source/power_switch_emulator.sv
source/harness_top.sv
bench/harness_chk.sv
bench/harness_monitor.sv
bench/harness_tb.sv

// ==== bench/harness_tb.sv ====
// -------------------------------------------------------------------------
// Runs the operations in bench/harness_stim.txt against harness_top.
// One register access at a time; comparing happens in harness_monitor.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module harness_tb;

  localparam int CLK_PERIOD = 8;
  localparam int PW = harness_pkg::NUM_POWER_DOMAINS;

  logic                               clk_i;
  logic                               rst_n_i;
  logic                               reg_valid_i;
  logic                               reg_write_i;
  logic [harness_pkg::ADDR_WIDTH-1:0] reg_addr_i;
  logic [harness_pkg::DATA_WIDTH-1:0] reg_wdata_i;
  logic                               reg_ready_o;
  logic                               reg_error_o;
  logic [harness_pkg::DATA_WIDTH-1:0] reg_rdata_o;
  logic                               gpio_i;
  logic                               gpio_o;
  logic                               irq_o;
  logic [PW-1:0]                      power_switch_n_i;
  logic [PW-1:0]                      power_switch_ack_n_o;

  logic [7:0]    op_q [$];
  logic [31:0]   addr_q [$];
  logic [31:0]   data_q [$];
  logic [31:0]   exp_q [$];
  int            bad_lines = 0;
  int            limit_cycles = 0;
  logic [PW-1:0] last_power = '1;

  harness_top dut0 (.*);

  harness_monitor mon0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_valid_i   (reg_valid_i),
    .reg_ready_i   (reg_ready_o),
    .reg_error_i   (reg_error_o),
    .reg_rdata_i   (reg_rdata_o),
    .gpio_pulse_i  (gpio_o),
    .irq_i         (irq_o),
    .power_ack_n_i (power_switch_ack_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // -------------------------------------------------------------------------
  // Stimulus file and run length
  // -------------------------------------------------------------------------
  task automatic load_stim();
    int         fd;
    int         rc;
    string      line;
    logic [7:0] op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("bench/harness_stim.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 7 || line[0] == "#") begin
        continue;
      end
      rc = $sscanf(line, "%c %h %h %h", op, a, d, e);
      if (rc != 4 || !(op inside {"W", "R", "E", "G", "P"})) begin
        $display("Malformed stimulus line: %s", line);
        bad_lines++;
        continue;
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  // Worst case per operation plus the largest idle gap, doubled
  function automatic int compute_limit();
    int cycles;
    cycles = 2 + harness_pkg::SWITCH_ACK_LATENCY + 4;
    foreach (op_q[k]) begin
      cycles += 4;
      case (op_q[k])
        "G":     cycles += data_q[k] * 8 + 7;
        "P":     cycles += 1;
        default: cycles += harness_pkg::SLOW_MEM_LATENCY + 2;
      endcase
    end
    return cycles * 2;
  endfunction

  // -------------------------------------------------------------------------
  // Operations
  // -------------------------------------------------------------------------
  task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
    @(posedge clk_i);
    mon0.expect_bus(op, addr, exp);
    reg_valid_i <= 1'b1;
    reg_write_i <= (op == "W");
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    do begin
      @(negedge clk_i);
    end while (reg_ready_o !== 1'b1);
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
  endtask

  // Slow pulses, well above the synchronizer delay
  task automatic run_gpio(input int pulses, input int exp_pulses, input logic exp_irq);
    @(posedge clk_i);
    mon0.start_gpio();
    for (int p = 0; p < pulses; p++) begin
      gpio_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      gpio_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
    repeat (6) @(posedge clk_i);
    mon0.check_gpio(pulses, exp_pulses, exp_irq);
  endtask

  task automatic drive_power(input logic [PW-1:0] pat);
    @(posedge clk_i);
    power_switch_n_i <= pat;
    mon0.expect_power(last_power, pat);
    last_power = pat;
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int seed;
    int gap;
    seed = $urandom(32'h35f8);
    rst_n_i = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    gpio_i = 1'b0;
    power_switch_n_i = '1;
    load_stim();
    if (op_q.size() == 0) begin
      $display("No operations could be read from bench/harness_stim.txt");
      $display("Result: FAILED");
      $finish;
    end else begin
      limit_cycles = compute_limit();
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (int k = 0; k < op_q.size(); k++) begin
        // Switch changes go out back to back
        gap = (op_q[k] == "P") ? 0 : $urandom % 4;
        repeat (gap) @(posedge clk_i);
        case (op_q[k])
          "G":     run_gpio(data_q[k], exp_q[k], addr_q[k][0]);
          "P":     drive_power(data_q[k][PW-1:0]);
          default: run_access(op_q[k], addr_q[k], data_q[k], exp_q[k]);
        endcase
      end
      repeat (harness_pkg::SWITCH_ACK_LATENCY + 4) @(posedge clk_i);
      mon0.report();
      if (mon0.fail_count == 0 && mon0.pass_count == op_q.size() && bad_lines == 0
          && dut0.chk0.assert_fails == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("%0d of %0d operations passed, %0d assertion failures",
                 mon0.pass_count, op_q.size(), dut0.chk0.assert_fails);
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== bench/harness_monitor.sv ====
// -------------------------------------------------------------------------
// Samples DUT outputs on falling edges and compares with expected results.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module harness_monitor (
  input logic                                      clk_i,
  input logic                                      rst_n_i,
  input logic                                      reg_valid_i,
  input logic                                      reg_ready_i,
  input logic                                      reg_error_i,
  input logic [harness_pkg::DATA_WIDTH-1:0]        reg_rdata_i,
  input logic                                      gpio_pulse_i,
  input logic                                      irq_i,
  input logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_ack_n_i
);

  int         pass_count = 0;
  int         fail_count = 0;
  int         wait_cycles = 0;
  int         neg_cnt = 0;
  int         pulse_cnt = 0;
  logic       irq_seen = 1'b0;
  logic       bus_pending = 1'b0;
  logic [7:0] bus_op;
  logic [31:0] bus_addr;
  logic [31:0] bus_exp;
  // Pending switch changes, oldest first
  int                                        pw_due [$];
  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] pw_old [$];
  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] pw_new [$];
  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] pw_early [$];
  logic                                      pw_ok [$];

  task automatic report_test(input bit ok, input string what, input string msg);
    if (ok) begin
      pass_count++;
      $display("%0t: ok   %s", $time, what);
    end else begin
      fail_count++;
      $display("CHECK FAILED at %0t: %s: %s", $time, what, msg);
    end
  endtask

  task automatic expect_bus(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] exp);
    bus_op = op;
    bus_addr = addr;
    bus_exp = exp;
    bus_pending = 1'b1;
  endtask

  task automatic finish_access();
    int    exp_wait;
    string what;
    exp_wait = (bus_addr < harness_pkg::SLOW_MEM_BASE + harness_pkg::SLOW_MEM_WORDS * 4)
             ? harness_pkg::SLOW_MEM_LATENCY : 0;
    what = $sformatf("%c 0x%08h", bus_op, bus_addr);
    if (!bus_pending) begin
      fail_count++;
      $display("Bus access completed at %0t with no access expected", $time);
    end else if (wait_cycles != exp_wait) begin
      report_test(0, what, $sformatf("ready after %0d cycles, expected %0d",
                                     wait_cycles, exp_wait));
    end else if (reg_error_i !== (bus_op == "E")) begin
      report_test(0, what, $sformatf("error %b, expected %b", reg_error_i, bus_op == "E"));
    end else if (bus_op != "W" && reg_rdata_i !== bus_exp) begin
      report_test(0, what, $sformatf("rdata 0x%08h, expected 0x%08h", reg_rdata_i, bus_exp));
    end else begin
      report_test(1, what, "");
    end
    bus_pending = 1'b0;
  endtask

  task automatic expect_power(input logic [harness_pkg::NUM_POWER_DOMAINS-1:0] old_pat,
                              input logic [harness_pkg::NUM_POWER_DOMAINS-1:0] new_pat);
    pw_due.push_back(neg_cnt + harness_pkg::SWITCH_ACK_LATENCY);
    pw_old.push_back(old_pat);
    pw_new.push_back(new_pat);
    pw_early.push_back(old_pat);
    pw_ok.push_back(1'b1);
  endtask

  // Old pattern one cycle before the latency, new pattern at it
  task automatic check_power();
    string what;
    for (int i = 0; i < pw_due.size(); i++) begin
      what = $sformatf("P %b", pw_new[i]);
      if (neg_cnt == pw_due[i] && power_ack_n_i !== pw_old[i]) begin
        pw_ok[i] = 1'b0;
        pw_early[i] = power_ack_n_i;
      end
      if (neg_cnt == pw_due[i] + 1) begin
        if (power_ack_n_i !== pw_new[i]) begin
          report_test(0, what, $sformatf("ack %b, expected %b", power_ack_n_i, pw_new[i]));
        end else if (!pw_ok[i]) begin
          report_test(0, what, $sformatf("ack %b before the latency, expected old %b",
                                         pw_early[i], pw_old[i]));
        end else begin
          report_test(1, what, "");
        end
      end
    end
    while (pw_due.size() > 0 && neg_cnt >= pw_due[0] + 1) begin
      void'(pw_due.pop_front());
      void'(pw_old.pop_front());
      void'(pw_new.pop_front());
      void'(pw_early.pop_front());
      void'(pw_ok.pop_front());
    end
  endtask

  task automatic start_gpio();
    pulse_cnt = 0;
  endtask

  task automatic check_gpio(input int pulses, input int exp_pulses, input logic exp_irq);
    string what;
    what = $sformatf("G %0d pulses", pulses);
    if (pulse_cnt != exp_pulses) begin
      report_test(0, what, $sformatf("gpio_o pulsed %0d times, expected %0d",
                                     pulse_cnt, exp_pulses));
    end else if (irq_seen !== exp_irq) begin
      report_test(0, what, $sformatf("irq_o %b, expected %b", irq_seen, exp_irq));
    end else begin
      report_test(1, what, "");
    end
  endtask

  task automatic report();
    $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
  endtask

  always @(negedge clk_i) begin
    neg_cnt++;
    if (gpio_pulse_i === 1'b1) begin
      pulse_cnt++;
    end
    irq_seen = irq_i;
    if (rst_n_i && reg_valid_i) begin
      if (reg_ready_i) begin
        finish_access();
        wait_cycles = 0;
      end else begin
        wait_cycles++;
      end
    end
    check_power();
  end

endmodule

// ==== bench/harness_chk.sv ====
// -------------------------------------------------------------------------
// Bus handshake and power acknowledge timing, bound into harness_top.
// Memory check assumes valid drops for a cycle between memory accesses.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module harness_chk (
  input logic                                      clk_i,
  input logic                                      rst_n_i,
  input logic                                      reg_valid_i,
  input logic                                      reg_write_i,
  input logic [harness_pkg::ADDR_WIDTH-1:0]        reg_addr_i,
  input logic [harness_pkg::DATA_WIDTH-1:0]        reg_wdata_i,
  input logic                                      reg_ready_i,
  input logic                                      mem_valid_i,
  input logic                                      mem_ready_i,
  input logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_switch_n_i,
  input logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_ack_n_i
);

  int assert_fails = 0;
  int since_rst_q;

  // Pipeline holds reset ones until it has filled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      since_rst_q <= 0;
    end else if (since_rst_q < harness_pkg::SWITCH_ACK_LATENCY) begin
      since_rst_q <= since_rst_q + 1;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_valid_i && !reg_ready_i |=> reg_valid_i && $stable(reg_write_i)
      && $stable(reg_addr_i) && $stable(reg_wdata_i))
    else begin
      assert_fails++;
      $error("Register request changed while waiting for ready");
    end

  a_mem_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_valid_i) |-> !mem_ready_i [*harness_pkg::SLOW_MEM_LATENCY] ##1 mem_ready_i)
    else begin
      assert_fails++;
      $error("Memory ready not at the fixed latency");
    end

  a_power_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    since_rst_q >= harness_pkg::SWITCH_ACK_LATENCY
      |-> power_ack_n_i == $past(power_switch_n_i, harness_pkg::SWITCH_ACK_LATENCY))
    else begin
      assert_fails++;
      $error("Power acknowledge differs from delayed request");
    end

endmodule

bind harness_top harness_chk chk0 (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .reg_valid_i      (reg_valid_i),
  .reg_write_i      (reg_write_i),
  .reg_addr_i       (reg_addr_i),
  .reg_wdata_i      (reg_wdata_i),
  .reg_ready_i      (reg_ready_o),
  .mem_valid_i      (mem_valid),
  .mem_ready_i      (mem_ready),
  .power_switch_n_i (power_switch_n_i),
  .power_ack_n_i    (power_switch_ack_n_o)
);

// ==== source/harness_top.sv ====
// -------------------------------------------------------------------------
// Peripheral side of the harness behind one register bus.
// One access outstanding at a time; the host holds its request until ready.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module harness_top (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Host register bus
  input  logic                                     reg_valid_i,
  input  logic                                     reg_write_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0]       reg_addr_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0]       reg_wdata_i,
  output logic                                     reg_ready_o,
  output logic                                     reg_error_o,
  output logic [harness_pkg::DATA_WIDTH-1:0]       reg_rdata_o,
  // GPIO counter pins
  input  logic                                     gpio_i,
  output logic                                     gpio_o,
  output logic                                     irq_o,
  // Power switches, active low
  input  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_switch_n_i,
  output logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_switch_ack_n_o
);

  logic                              mem_valid;
  logic                              mem_ready;
  logic [harness_pkg::DATA_WIDTH-1:0] mem_rdata;
  logic                              cnt_valid;
  logic                              cnt_ready;
  logic [harness_pkg::DATA_WIDTH-1:0] cnt_rdata;

  // -------------------------------------------------------------------------
  // Register bus fan-out
  // -------------------------------------------------------------------------
  reg_decoder u_reg_decoder (
    .reg_valid_i (reg_valid_i),
    .reg_addr_i  (reg_addr_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .mem_valid_o (mem_valid),
    .cnt_valid_o (cnt_valid),
    .mem_ready_i (mem_ready),
    .cnt_ready_i (cnt_ready),
    .mem_rdata_i (mem_rdata),
    .cnt_rdata_i (cnt_rdata)
  );

  slow_memory u_slow_memory (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mem_valid),
    .write_i (reg_write_i),
    .addr_i  (reg_addr_i),
    .wdata_i (reg_wdata_i),
    .ready_o (mem_ready),
    .rdata_o (mem_rdata)
  );

  gpio_counter u_gpio_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (cnt_valid),
    .write_i (reg_write_i),
    .addr_i  (reg_addr_i),
    .wdata_i (reg_wdata_i),
    .ready_o (cnt_ready),
    .rdata_o (cnt_rdata),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .irq_o   (irq_o)
  );

  // -------------------------------------------------------------------------
  // Power switch acknowledge
  // -------------------------------------------------------------------------
  power_switch_emulator u_power_switch_emulator (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .power_switch_n_i     (power_switch_n_i),
    .power_switch_ack_n_o (power_switch_ack_n_o)
  );

endmodule

// ==== source/power_switch_emulator.sv ====
// -------------------------------------------------------------------------
// Acknowledge of each power switch request after SWITCH_ACK_LATENCY cycles.
// Active low; every domain reads as switched off out of reset.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module power_switch_emulator (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_switch_n_i,
  output logic [harness_pkg::NUM_POWER_DOMAINS-1:0] power_switch_ack_n_o
);

  // One lane per domain, any number of changes in flight
  logic [harness_pkg::NUM_POWER_DOMAINS-1:0] ack_pipe_q [harness_pkg::SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < harness_pkg::SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '1;
      end
    end else begin
      ack_pipe_q[0] <= power_switch_n_i;
      for (int i = 1; i < harness_pkg::SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  assign power_switch_ack_n_o = ack_pipe_q[harness_pkg::SWITCH_ACK_LATENCY-1];

endmodule

// ==== source/gpio_counter.sv ====
// -------------------------------------------------------------------------
// GPIO rising-edge counter with wrap pulse and sticky interrupt.
// Registers are zero-wait; a count lands 3 cycles after the input edge.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module gpio_counter (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               valid_i,
  input  logic                               write_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                               ready_o,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o,
  input  logic                               gpio_i,
  output logic                               gpio_o,
  output logic                               irq_o
);

  logic [1:0]                         sync_q;
  logic                               prev_q;
  logic                               rise;
  logic [harness_pkg::DATA_WIDTH-1:0] count_q;
  logic [harness_pkg::DATA_WIDTH-1:0] count_next;
  logic [harness_pkg::DATA_WIDTH-1:0] max_q;
  logic                               wrap;
  logic                               gpio_q;
  logic                               irq_q;
  logic                               wr_max;
  logic                               irq_clr;
  harness_pkg::gpio_cnt_reg_e         reg_sel;

  // -------------------------------------------------------------------------
  // Input synchronizer and edge detect
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], gpio_i};
      prev_q <= sync_q[1];
    end
  end

  assign rise = sync_q[1] & ~prev_q;

  // -------------------------------------------------------------------------
  // Register decode
  // -------------------------------------------------------------------------
  assign reg_sel = harness_pkg::gpio_cnt_reg_e'(addr_i[harness_pkg::GPIO_CNT_OFF_WIDTH-1:0]);
  assign wr_max  = valid_i && write_i && (reg_sel == harness_pkg::CNT_MAX);
  assign irq_clr = valid_i && write_i && (reg_sel == harness_pkg::CNT_STATUS) && wdata_i[0];

  // Limit write restarts the count, so it also masks a same-cycle edge
  assign count_next = count_q + 1'b1;
  assign wrap       = rise && !wr_max && (count_next >= max_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      max_q   <= harness_pkg::GPIO_CNT_DEFAULT_MAX;
      gpio_q  <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      gpio_q <= wrap;
      // Set wins over a clear in the same cycle
      irq_q  <= wrap | (irq_q & ~irq_clr);
      if (wr_max) begin
        max_q   <= wdata_i;
        count_q <= '0;
      end else if (wrap) begin
        count_q <= '0;
      end else if (rise) begin
        count_q <= count_next;
      end
    end
  end

  always_comb begin
    case (reg_sel)
      harness_pkg::CNT_VALUE:  rdata_o = count_q;
      harness_pkg::CNT_MAX:    rdata_o = max_q;
      harness_pkg::CNT_STATUS: rdata_o = {{(harness_pkg::DATA_WIDTH-1){1'b0}}, irq_q};
      default:                 rdata_o = '0;
    endcase
  end

  assign ready_o = valid_i;
  assign gpio_o  = gpio_q;
  assign irq_o   = irq_q;

endmodule

// ==== slow_memory/slow_memory.sv ====
// -------------------------------------------------------------------------
// Word memory, ready a fixed SLOW_MEM_LATENCY cycles after valid is seen.
// Low two address bits ignored. Contents cleared by reset.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module slow_memory (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               valid_i,
  input  logic                               write_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                               ready_o,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);

  harness_pkg::slow_mem_state_e                state_q;
  harness_pkg::slow_mem_state_e                state_d;
  logic [harness_pkg::SLOW_MEM_CNT_WIDTH-1:0]  wait_cnt_q;
  logic [harness_pkg::SLOW_MEM_IDX_WIDTH-1:0]  word_idx;
  logic                                        ready_q;
  logic [harness_pkg::DATA_WIDTH-1:0]          rdata_q;
  logic [harness_pkg::DATA_WIDTH-1:0]          mem_q [harness_pkg::SLOW_MEM_WORDS];

  assign word_idx = addr_i[harness_pkg::SLOW_MEM_IDX_WIDTH+1:2];

  // -------------------------------------------------------------------------
  // Access FSM
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      harness_pkg::MEM_IDLE: begin
        if (valid_i) begin
          state_d = harness_pkg::MEM_WAIT;
        end
      end
      harness_pkg::MEM_WAIT: begin
        if (wait_cnt_q == '0) begin
          state_d = harness_pkg::MEM_RESP;
        end
      end
      default: begin
        state_d = harness_pkg::MEM_IDLE;
      end
    endcase
  end

  // WAIT lasts LATENCY-1 cycles, so RESP lands LATENCY cycles after valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= harness_pkg::MEM_IDLE;
      wait_cnt_q <= '0;
      ready_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == harness_pkg::MEM_RESP);
      if (state_q == harness_pkg::MEM_IDLE) begin
        wait_cnt_q <= harness_pkg::SLOW_MEM_CNT_WIDTH'(harness_pkg::SLOW_MEM_LATENCY - 2);
      end else if (state_q == harness_pkg::MEM_WAIT && wait_cnt_q != '0) begin
        wait_cnt_q <= wait_cnt_q - 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Storage
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < harness_pkg::SLOW_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (state_q == harness_pkg::MEM_RESP && write_i) begin
      mem_q[word_idx] <= wdata_i;
    end
  end

  // Read word captured on the way into RESP
  always_ff @(posedge clk_i) begin
    if (state_q == harness_pkg::MEM_WAIT && state_d == harness_pkg::MEM_RESP) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

endmodule

// ==== source/reg_decoder.sv ====
// -------------------------------------------------------------------------
// Combinational decode of the register bus onto the two peripherals.
// Addresses outside both regions complete at once with error and zero data.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module reg_decoder (
  // Request side
  input  logic                               reg_valid_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  // Response side
  output logic                               reg_ready_o,
  output logic [harness_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                               reg_error_o,
  // Peripheral ports
  output logic                               mem_valid_o,
  output logic                               cnt_valid_o,
  input  logic                               mem_ready_i,
  input  logic                               cnt_ready_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] mem_rdata_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] cnt_rdata_i
);

  logic [harness_pkg::ADDR_WIDTH-1:0] mem_off;
  logic [harness_pkg::ADDR_WIDTH-1:0] cnt_off;
  logic                               mem_hit;
  logic                               cnt_hit;
  harness_pkg::periph_sel_e           sel;

  // Unsigned offset compare covers both region bounds
  assign mem_off = reg_addr_i - harness_pkg::SLOW_MEM_BASE;
  assign cnt_off = reg_addr_i - harness_pkg::GPIO_CNT_BASE;
  assign mem_hit = (mem_off < harness_pkg::SLOW_MEM_SPAN);
  assign cnt_hit = (cnt_off < harness_pkg::GPIO_CNT_SPAN);

  always_comb begin
    if (mem_hit) begin
      sel = harness_pkg::PERIPH_SLOW_MEM;
    end else if (cnt_hit) begin
      sel = harness_pkg::PERIPH_GPIO_CNT;
    end else begin
      sel = harness_pkg::PERIPH_NONE;
    end
  end

  // -------------------------------------------------------------------------
  // Request routing and response select
  // -------------------------------------------------------------------------
  always_comb begin
    mem_valid_o = 1'b0;
    cnt_valid_o = 1'b0;
    reg_ready_o = 1'b0;
    reg_error_o = 1'b0;
    reg_rdata_o = '0;
    case (sel)
      harness_pkg::PERIPH_SLOW_MEM: begin
        mem_valid_o = reg_valid_i;
        reg_ready_o = mem_ready_i;
        reg_rdata_o = mem_rdata_i;
      end
      harness_pkg::PERIPH_GPIO_CNT: begin
        cnt_valid_o = reg_valid_i;
        reg_ready_o = cnt_ready_i;
        reg_rdata_o = cnt_rdata_i;
      end
      default: begin
        // Miss answered here, zero wait
        reg_ready_o = reg_valid_i;
        reg_error_o = reg_valid_i;
      end
    endcase
  end

endmodule

// ==== common/harness_pkg.sv ====
// -------------------------------------------------------------------------
// Address map, bus widths and latencies for the peripheral harness.
// Regions must be aligned to their size. SLOW_MEM_LATENCY must be 2 or more.
// -------------------------------------------------------------------------

package harness_pkg;

  // -------------------------------------------------------------------------
  // Register bus
  // -------------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // -------------------------------------------------------------------------
  // Address map
  // -------------------------------------------------------------------------
  localparam logic [ADDR_WIDTH-1:0] SLOW_MEM_BASE = 32'h0000_0000;
  localparam int unsigned SLOW_MEM_WORDS = 1024;
  localparam logic [ADDR_WIDTH-1:0] SLOW_MEM_SPAN = SLOW_MEM_WORDS * 4;
  localparam int unsigned SLOW_MEM_IDX_WIDTH = $clog2(SLOW_MEM_WORDS);

  localparam logic [ADDR_WIDTH-1:0] GPIO_CNT_BASE = 32'h0001_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_CNT_SPAN = 32'd16;
  localparam int unsigned GPIO_CNT_OFF_WIDTH = $clog2(GPIO_CNT_SPAN);

  // -------------------------------------------------------------------------
  // Timing and reset values
  // -------------------------------------------------------------------------
  localparam int unsigned SLOW_MEM_LATENCY = 4;
  // Wait counter only has to hold LATENCY-2
  localparam int unsigned SLOW_MEM_CNT_WIDTH = $clog2(SLOW_MEM_LATENCY);

  localparam logic [DATA_WIDTH-1:0] GPIO_CNT_DEFAULT_MAX = 32'd2048;

  // CPU, peripheral and external domains
  localparam int unsigned NUM_POWER_DOMAINS = 3;
  localparam int unsigned SWITCH_ACK_LATENCY = 16;

  // -------------------------------------------------------------------------
  // Enums
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    PERIPH_SLOW_MEM = 2'd0,
    PERIPH_GPIO_CNT = 2'd1,
    PERIPH_NONE     = 2'd2
  } periph_sel_e;

  // Byte offsets inside the counter region
  typedef enum logic [GPIO_CNT_OFF_WIDTH-1:0] {
    CNT_VALUE  = 4'h0,
    CNT_MAX    = 4'h4,
    CNT_STATUS = 4'h8
  } gpio_cnt_reg_e;

  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,
    MEM_WAIT = 2'd1,
    MEM_RESP = 2'd2
  } slow_mem_state_e;

endpackage
